/* common/ccd_pipeline_pkg.sv */
// Shared widths, pixel types and hue constants of the CCD pixel path
package ccd_pipeline_pkg;

  // ==============================
  // Sample and coordinate widths
  // ==============================
  localparam int raw_width = 12;            // Bits per sensor sample
  localparam int coord_width = 12;          // Column and row counters
  localparam int frame_count_width = 32;
  localparam int hue_width = 8;
  localparam int pixel_word_width = 16;

  typedef logic [raw_width-1:0] raw_pixel_t;          // Raw sample or RGB component
  typedef logic [coord_width-1:0] coord_t;
  typedef logic [frame_count_width-1:0] frame_count_t;
  typedef logic [hue_width-1:0] hue_t;                // Full circle on 0..255
  typedef logic [pixel_word_width-1:0] pixel_word_t;

  // ==============================
  // Branch constants
  // ==============================
  localparam int word_component_bits = 5;   // RGB555 field width
  localparam int hue_input_bits = 8;        // Top component bits seen by hue

  // Hue circle in 256 steps, six sectors
  localparam int hue_sector_span = 43;
  localparam int hue_green_base = 85;       // Green max sector
  localparam int hue_blue_base = 171;       // Blue max sector

  // Raw samples per line the line buffer can hold
  localparam int default_max_line_width = 1280;

endpackage

/* ccd_capture/ccd_capture.sv */
// CCD capture, input registers, start-gated frames, pixel coordinates, frame count
module ccd_capture (
  input  logic                           ccd_pixel_clk,
  input  logic                           reset,
  input  ccd_pipeline_pkg::raw_pixel_t   ccd_data,
  input  logic                           ccd_frame_valid,
  input  logic                           ccd_line_valid,
  input  logic                           start,
  output ccd_pipeline_pkg::raw_pixel_t   sample,
  output logic                           sample_valid,
  output ccd_pipeline_pkg::coord_t       column,
  output ccd_pipeline_pkg::coord_t       row,
  output ccd_pipeline_pkg::frame_count_t frame_count
);

  ccd_pipeline_pkg::raw_pixel_t data_q;   // Registered sensor data
  logic                         fval_q;
  logic                         lval_q;
  logic                         fval_d;   // One more cycle for edges
  logic                         lval_d;
  logic                         frame_active;
  ccd_pipeline_pkg::coord_t     col_count;
  ccd_pipeline_pkg::coord_t     row_count;
  logic                         frame_rise;
  logic                         frame_fall;
  logic                         line_fall;
  logic                         capture_now;

  // ==============================
  // Input registers
  // ==============================
  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= ccd_data;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_q <= ccd_frame_valid;
      lval_q <= ccd_line_valid;
      fval_d <= fval_q;
      lval_d <= lval_q;
    end
  end

  assign frame_rise = fval_q & ~fval_d;
  assign frame_fall = ~fval_q & fval_d;
  assign line_fall  = ~lval_q & lval_d;

  // Start only matters on the frame's first cycle
  assign capture_now = (frame_active | (frame_rise & start)) & fval_q & lval_q;

  // ==============================
  // Frame gating and counters
  // ==============================
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      frame_active <= 1'b0;
      frame_count  <= '0;
      sample_valid <= 1'b0;
      col_count    <= '0;
      row_count    <= '0;
    end else begin
      sample_valid <= capture_now;
      if (frame_rise) begin
        frame_active <= start;
      end else if (frame_fall) begin
        frame_active <= 1'b0;
        if (frame_active) begin
          frame_count <= frame_count + 1'b1;  // Captured frames only
        end
      end
      if (capture_now) begin
        col_count <= col_count + 1'b1;
      end else if (line_fall) begin
        col_count <= '0;                      // Next line starts at column 0
        row_count <= row_count + 1'b1;
      end
      if (frame_rise) begin
        row_count <= '0;
      end
    end
  end

  // Payload, no reset
  always_ff @(posedge ccd_pixel_clk) begin
    if (capture_now) begin
      sample <= data_q;
      column <= col_count;
      row    <= frame_rise ? '0 : row_count;  // Line may open with the frame
    end
  end

  // Sensor never opens a line outside a frame
  a_line_in_frame : assert property (
    @(posedge ccd_pixel_clk) disable iff (reset)
    (lval_q & ~lval_d) |-> fval_q
  );

endmodule

/* bayer_demosaic/bayer_demosaic.sv */
// Bayer demosaic, even-row line buffer and 2x2 block reduction to one RGB pixel
module bayer_demosaic #(
  parameter int max_line_width = ccd_pipeline_pkg::default_max_line_width
) (
  input  logic                         ccd_pixel_clk,
  input  logic                         reset,
  input  ccd_pipeline_pkg::raw_pixel_t sample,
  input  logic                         sample_valid,
  input  ccd_pipeline_pkg::coord_t     column,
  input  ccd_pipeline_pkg::coord_t     row,
  output ccd_pipeline_pkg::raw_pixel_t red,
  output ccd_pipeline_pkg::raw_pixel_t green,
  output ccd_pipeline_pkg::raw_pixel_t blue,
  output logic                         rgb_valid
);

  localparam int pw = ccd_pipeline_pkg::raw_width;
  localparam int pair_depth = max_line_width / 2;  // One entry per column pair
  localparam int addr_width = $clog2(pair_depth);

  // Pattern
  //   even row  G R G R ...
  //   odd row   B G B G ...

  // ==============================
  // Line buffer of even-row pairs
  // ==============================
  logic [2*pw-1:0]              line_buf [pair_depth];  // {green, red}
  logic [2*pw-1:0]              pair_rd;
  logic [addr_width-1:0]        pair_addr;
  ccd_pipeline_pkg::raw_pixel_t hold;        // Even-column sample of this row
  logic [pw:0]                  green_sum;   // One extra bit for the carry
  logic                         block_done;

  assign pair_addr  = addr_width'(column >> 1);
  assign pair_rd    = line_buf[pair_addr];          // Stored G R above this block
  assign block_done = sample_valid & row[0] & column[0];
  assign green_sum  = {1'b0, pair_rd[2*pw-1 -: pw]} + {1'b0, sample};

  always_ff @(posedge ccd_pixel_clk) begin
    if (sample_valid & ~column[0]) begin
      hold <= sample;                               // Green on even rows, blue on odd
    end
    if (sample_valid & ~row[0] & column[0]) begin
      line_buf[pair_addr] <= {hold, sample};
    end
    // Block completes on the odd-row green
    if (block_done) begin
      red   <= pair_rd[pw-1:0];
      green <= green_sum[pw:1];                     // Mean, fraction dropped
      blue  <= hold;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= block_done;
    end
  end

  // Capture never hands over a line longer than the buffer
  a_column_in_range : assert property (
    @(posedge ccd_pixel_clk) disable iff (reset)
    sample_valid |-> (column < max_line_width)
  );

endmodule

/* verilog/rgb555_packer.sv */
// RGB555 packer, 5-bit truncation with per-channel enables, registered word
module rgb555_packer (
  input  logic                          ccd_pixel_clk,
  input  logic                          reset,
  input  ccd_pipeline_pkg::raw_pixel_t  red,
  input  ccd_pipeline_pkg::raw_pixel_t  green,
  input  ccd_pipeline_pkg::raw_pixel_t  blue,
  input  logic                          rgb_valid,
  input  logic [2:0]                    channel_enable,  // [0] red, [1] green, [2] blue
  output ccd_pipeline_pkg::pixel_word_t rgb_word,
  output logic                          rgb_word_valid
);

  localparam int rw = ccd_pipeline_pkg::raw_width;
  localparam int cw = ccd_pipeline_pkg::word_component_bits;

  // Word is {0, R, G, B}, disabled fields forced to zero
  always_ff @(posedge ccd_pixel_clk) begin
    rgb_word <= {1'b0,
                 red[rw-1 -: cw] & {cw{channel_enable[0]}},
                 green[rw-1 -: cw] & {cw{channel_enable[1]}},
                 blue[rw-1 -: cw] & {cw{channel_enable[2]}}};
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      rgb_word_valid <= 1'b0;
    end else begin
      rgb_word_valid <= rgb_valid;
    end
  end

endmodule

/* hue_calc/hue_calc.sv */
// Hue calculator, three-stage pipelined integer hue on the top component bits
module hue_calc (
  input  logic                         ccd_pixel_clk,
  input  logic                         reset,
  input  ccd_pipeline_pkg::raw_pixel_t red,
  input  ccd_pipeline_pkg::raw_pixel_t green,
  input  ccd_pipeline_pkg::raw_pixel_t blue,
  input  logic                         rgb_valid,
  output ccd_pipeline_pkg::hue_t       hue,
  output logic                         hue_valid
);

  localparam int rw = ccd_pipeline_pkg::raw_width;
  localparam int hw = ccd_pipeline_pkg::hue_input_bits;
  localparam logic signed [15:0] span_s = 16'(ccd_pipeline_pkg::hue_sector_span);

  logic [hw-1:0]        r8;
  logic [hw-1:0]        g8;
  logic [hw-1:0]        b8;
  logic [1:0]           sector_c;   // 0 red, 1 green, 2 blue max
  logic [hw-1:0]        max_c;
  logic [hw-1:0]        min_c;
  logic signed [hw:0]   delta_c;    // Sector difference
  logic [1:0]           s1_sector;
  logic signed [hw:0]   s1_delta;
  logic [hw-1:0]        s1_diff;
  logic                 s1_valid;
  logic signed [15:0]   scaled;
  logic signed [7:0]    quot_c;
  logic [1:0]           s2_sector;
  logic signed [7:0]    s2_quot;
  logic                 s2_valid;
  ccd_pipeline_pkg::hue_t base_c;

  assign r8 = red[rw-1 -: hw];
  assign g8 = green[rw-1 -: hw];
  assign b8 = blue[rw-1 -: hw];

  // ==============================
  // Stage 1, max, min, difference
  // ==============================
  always_comb begin
    if (r8 >= g8 && r8 >= b8) begin             // Red wins ties
      sector_c = 2'd0;
      max_c    = r8;
      delta_c  = $signed({1'b0, g8}) - $signed({1'b0, b8});
    end else if (g8 >= b8) begin                // Then green
      sector_c = 2'd1;
      max_c    = g8;
      delta_c  = $signed({1'b0, b8}) - $signed({1'b0, r8});
    end else begin
      sector_c = 2'd2;
      max_c    = b8;
      delta_c  = $signed({1'b0, r8}) - $signed({1'b0, g8});
    end
    if (r8 <= g8 && r8 <= b8) begin
      min_c = r8;
    end else if (g8 <= b8) begin
      min_c = g8;
    end else begin
      min_c = b8;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    s1_sector <= sector_c;
    s1_delta  <= delta_c;
    s1_diff   <= max_c - min_c;
  end

  // ==============================
  // Stage 2, scaled quotient
  // ==============================
  // Span applied before the divide, truncation toward zero
  assign scaled = 16'(s1_delta) * span_s;
  assign quot_c = (s1_diff == '0) ? '0 : 8'(scaled / $signed({8'b0, s1_diff}));

  always_ff @(posedge ccd_pixel_clk) begin
    s2_sector <= s1_sector;
    s2_quot   <= quot_c;                        // Grey lands on 0
  end

  // ==============================
  // Stage 3, sector base
  // ==============================
  always_comb begin
    case (s2_sector)
      2'd1:    base_c = 8'(ccd_pipeline_pkg::hue_green_base);
      2'd2:    base_c = 8'(ccd_pipeline_pkg::hue_blue_base);
      default: base_c = '0;
    endcase
  end

  always_ff @(posedge ccd_pixel_clk) begin
    hue <= base_c + s2_quot;                    // Wraps modulo 256
  end

  // Valid strobe alongside the data
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      hue_valid <= 1'b0;
    end else begin
      s1_valid  <= rgb_valid;
      s2_valid  <= s1_valid;
      hue_valid <= s2_valid;
    end
  end

  // Sector difference lies within max minus min, so one step stays inside its sector
  a_quotient_in_sector : assert property (
    @(posedge ccd_pixel_clk) disable iff (reset)
    s1_valid |-> (quot_c <= span_s) && (quot_c >= -span_s)
  );

endmodule

/* verilog/pixel_word_select.sv */
// Pixel word selector, RGB555 or hue branch by mode, registered output
module pixel_word_select (
  input  logic                          ccd_pixel_clk,
  input  logic                          reset,
  input  logic                          hue_mode,
  input  ccd_pipeline_pkg::pixel_word_t rgb_word,
  input  logic                          rgb_word_valid,
  input  ccd_pipeline_pkg::hue_t        hue,
  input  logic                          hue_valid,
  output ccd_pipeline_pkg::pixel_word_t pixel_word,
  output logic                          pixel_word_valid
);

  logic [2:0] pending;   // RGB words whose hue is still in flight

  always_ff @(posedge ccd_pixel_clk) begin
    pixel_word <= hue_mode ? {8'h00, hue} : rgb_word;   // Hue in low byte
  end

  // Chosen branch's strobe only
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      pixel_word_valid <= 1'b0;
      pending          <= '0;
    end else begin
      pixel_word_valid <= hue_mode ? hue_valid : rgb_word_valid;
      pending          <= pending + 3'(rgb_word_valid) - 3'(hue_valid);
    end
  end

  // ==============================
  // Branch balance
  // ==============================
  // Hue trails RGB by two cycles, so counts match once the stream goes quiet
  a_branches_balance : assert property (
    @(posedge ccd_pixel_clk) disable iff (reset)
    (!rgb_word_valid [*2]) |=> (pending == '0)
  );

  a_hue_has_rgb : assert property (
    @(posedge ccd_pixel_clk) disable iff (reset)
    hue_valid |-> (pending != '0) && (pending <= 3'd2)
  );

endmodule

/* verilog/ccd_pipeline_top.sv */
// CCD pixel path top level, capture to demosaic to RGB555 and hue branches
module ccd_pipeline_top #(
  parameter int max_line_width = ccd_pipeline_pkg::default_max_line_width
) (
  input  logic                           ccd_pixel_clk,
  input  logic                           reset,
  input  ccd_pipeline_pkg::raw_pixel_t   ccd_data,
  input  logic                           ccd_frame_valid,
  input  logic                           ccd_line_valid,
  input  logic                           start,
  input  logic                           hue_mode,        // 1 selects hue word
  input  logic [2:0]                     channel_enable,  // [0] red, [1] green, [2] blue
  output ccd_pipeline_pkg::pixel_word_t  pixel_word,
  output logic                           pixel_word_valid,
  output ccd_pipeline_pkg::frame_count_t frame_count
);

  // ==============================
  // Inter-stage signals
  // ==============================
  ccd_pipeline_pkg::raw_pixel_t  sample;
  logic                          sample_valid;
  ccd_pipeline_pkg::coord_t      column;
  ccd_pipeline_pkg::coord_t      row;
  ccd_pipeline_pkg::raw_pixel_t  red;
  ccd_pipeline_pkg::raw_pixel_t  green;
  ccd_pipeline_pkg::raw_pixel_t  blue;
  logic                          rgb_valid;
  ccd_pipeline_pkg::pixel_word_t rgb_word;
  logic                          rgb_word_valid;
  ccd_pipeline_pkg::hue_t        hue;
  logic                          hue_valid;

  // Sensor inputs, 2 cycles to a captured sample
  ccd_capture u_capture (
    .ccd_pixel_clk   (ccd_pixel_clk),
    .reset           (reset),
    .ccd_data        (ccd_data),
    .ccd_frame_valid (ccd_frame_valid),
    .ccd_line_valid  (ccd_line_valid),
    .start           (start),
    .sample          (sample),
    .sample_valid    (sample_valid),
    .column          (column),
    .row             (row),
    .frame_count     (frame_count)
  );

  // One RGB pixel per 2x2 block
  bayer_demosaic #(
    .max_line_width (max_line_width)
  ) u_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .column        (column),
    .row           (row),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .rgb_valid     (rgb_valid)
  );

  rgb555_packer u_packer (
    .ccd_pixel_clk  (ccd_pixel_clk),
    .reset          (reset),
    .red            (red),
    .green          (green),
    .blue           (blue),
    .rgb_valid      (rgb_valid),
    .channel_enable (channel_enable),
    .rgb_word       (rgb_word),
    .rgb_word_valid (rgb_word_valid)
  );

  hue_calc u_hue (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .rgb_valid     (rgb_valid),
    .hue           (hue),
    .hue_valid     (hue_valid)
  );

  // Output word, RGB 5 cycles or hue 7 cycles after the block's last sample
  pixel_word_select u_select (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .reset            (reset),
    .hue_mode         (hue_mode),
    .rgb_word         (rgb_word),
    .rgb_word_valid   (rgb_word_valid),
    .hue              (hue),
    .hue_valid        (hue_valid),
    .pixel_word       (pixel_word),
    .pixel_word_valid (pixel_word_valid)
  );

endmodule

/* verification/ccd_pipeline_checker.sv */
// Scoreboard for the CCD pixel path, reference model, expected words and per-test report
module ccd_pipeline_checker #(
  parameter int frame_cols = 8,
  parameter int frame_rows = 6
) (
  input  logic                           ccd_pixel_clk,
  input  logic                           reset,
  input  ccd_pipeline_pkg::raw_pixel_t   ccd_data,
  input  logic                           ccd_frame_valid,
  input  logic                           ccd_line_valid,
  input  logic                           start,
  input  logic                           hue_mode,
  input  logic [2:0]                     channel_enable,
  input  ccd_pipeline_pkg::pixel_word_t  pixel_word,
  input  logic                           pixel_word_valid,
  input  ccd_pipeline_pkg::frame_count_t frame_count,
  input  int                             test_id,
  input  logic                           test_end,     // One-cycle strobe from the testbench
  output int                             outstanding,  // Words still due from the DUT
  output int                             error_count,
  output int                             word_count
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int blocks_per_frame = (frame_cols / 2) * (frame_rows / 2);
  localparam int hue_shift = ccd_pipeline_pkg::raw_width - ccd_pipeline_pkg::hue_input_bits;
  localparam int field_shift = ccd_pipeline_pkg::raw_width - ccd_pipeline_pkg::word_component_bits;

  ccd_pipeline_pkg::pixel_word_t expected_q [$];
  ccd_pipeline_pkg::raw_pixel_t  line_pair [2][frame_cols];  // Top and bottom row of a block
  ccd_pipeline_pkg::pixel_word_t exp_word;
  logic fv_prev;
  logic lv_prev;
  logic rise_pending;    // Frame-valid rose one cycle ago
  logic capturing;
  int   row;
  int   col;
  int   frames_captured;
  int   test_frames;
  int   test_words;
  int   test_errors;

  // ==============================
  // Reference model
  // ==============================
  // Block is G R over B G, one output word per block
  function automatic ccd_pipeline_pkg::pixel_word_t ref_word(
    input ccd_pipeline_pkg::raw_pixel_t g_top,
    input ccd_pipeline_pkg::raw_pixel_t r_top,
    input ccd_pipeline_pkg::raw_pixel_t b_bot,
    input ccd_pipeline_pkg::raw_pixel_t g_bot,
    input logic                         mode,
    input logic [2:0]                   en
  );
    int         g_avg;
    int         r8;
    int         g8;
    int         b8;
    int         mx;
    int         mn;
    int         num;
    int         base;
    int         q;
    logic [7:0] h;
    logic [4:0] rf;
    logic [4:0] gf;
    logic [4:0] bf;
    g_avg = (int'(g_top) + int'(g_bot)) / 2;   // Fraction dropped
    rf = en[0] ? 5'(int'(r_top) >> field_shift) : 5'd0;
    gf = en[1] ? 5'(g_avg >> field_shift) : 5'd0;
    bf = en[2] ? 5'(int'(b_bot) >> field_shift) : 5'd0;
    r8 = int'(r_top) >> hue_shift;
    g8 = g_avg >> hue_shift;
    b8 = int'(b_bot) >> hue_shift;
    if (r8 >= g8 && r8 >= b8) begin           // Red first on ties
      mx = r8;
      num = g8 - b8;
      base = 0;
    end else if (g8 >= b8) begin
      mx = g8;
      num = b8 - r8;
      base = ccd_pipeline_pkg::hue_green_base;
    end else begin
      mx = b8;
      num = r8 - g8;
      base = ccd_pipeline_pkg::hue_blue_base;
    end
    mn = (r8 < g8) ? r8 : g8;
    mn = (b8 < mn) ? b8 : mn;
    if (mx == mn) begin
      h = 8'd0;                                 // Grey
    end else begin
      q = (num * ccd_pipeline_pkg::hue_sector_span) / (mx - mn);  // Toward zero
      h = 8'((base + q + 256) % 256);
    end
    return mode ? {8'h00, h} : {1'b0, rf, gf, bf};
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "rgb all channels";
      2:       return "green only";
      3:       return "hue directed and random";
      4:       return "start gating";
      default: return "frame count run";
    endcase
  endfunction

  task automatic count_error();
    error_count++;
    test_errors++;
  endtask

  // ==============================
  // Compare and track
  // ==============================
  always @(posedge ccd_pixel_clk) begin
    if (reset) begin
      expected_q.delete();
      fv_prev = 1'b0;
      lv_prev = 1'b0;
      rise_pending = 1'b0;
      capturing = 1'b0;
      row = 0;
      col = 0;
      frames_captured = 0;
      test_frames = 0;
      test_words = 0;
      test_errors = 0;
      error_count = 0;
      word_count = 0;
    end else begin
      if (pixel_word_valid) begin
        word_count++;
        test_words++;
        if (expected_q.size() == 0) begin
          $display("Error at %0d ns: unexpected pixel word %h, none was due", $time, pixel_word);
          count_error();
        end else begin
          exp_word = expected_q.pop_front();
          if (pixel_word !== exp_word) begin
            $display("Mismatch at %0d ns: pixel_word %h, expected %h",
                     $time, pixel_word, exp_word);
            count_error();
          end
        end
      end
      if (rise_pending) begin
        capturing = start;                      // Start seen at the registered edge
        rise_pending = 1'b0;
      end
      if (ccd_frame_valid && !fv_prev) begin
        rise_pending = 1'b1;
        row = 0;
        col = 0;
      end
      if (!ccd_frame_valid && fv_prev) begin
        if (capturing) begin
          frames_captured++;
          test_frames++;
        end
        capturing = 1'b0;
      end
      if (capturing && ccd_frame_valid && ccd_line_valid && col < frame_cols) begin
        line_pair[row % 2][col] = ccd_data;
        if (row % 2 == 1 && col % 2 == 1) begin  // Block complete
          expected_q.push_back(ref_word(line_pair[0][col-1], line_pair[0][col],
                                        line_pair[1][col-1], ccd_data,
                                        hue_mode, channel_enable));
        end
        col++;
      end
      if (lv_prev && !ccd_line_valid) begin
        row++;
        col = 0;
      end
      fv_prev = ccd_frame_valid;
      lv_prev = ccd_line_valid;

      // Per-test summary
      if (test_end) begin
        if (expected_q.size() != 0) begin
          $display("Error at %0d ns: %0d expected words never came out",
                   $time, expected_q.size());
          count_error();
          expected_q.delete();
        end
        if (test_words != blocks_per_frame * test_frames) begin
          $display("Error at %0d ns: %0d words for %0d captured frames",
                   $time, test_words, test_frames);
          count_error();
        end
        if (frame_count !== ccd_pipeline_pkg::frame_count_t'(frames_captured)) begin
          $display("Mismatch at %0d ns: frame_count %0d, expected %0d",
                   $time, frame_count, frames_captured);
          count_error();
        end
        $display("Test %0d (%s) done: %0d frames, %0d words, %0d errors",
                 test_id, test_name(test_id), test_frames, test_words, test_errors);
        test_frames = 0;
        test_words = 0;
        test_errors = 0;
      end
      outstanding = expected_q.size();
    end
  end

endmodule

/* verification/ccd_pipeline_tb.sv */
// Testbench for the CCD pixel path, clock, reset, sensor frames and test sequence
module ccd_pipeline_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int frame_cols = 8;
  localparam int frame_rows = 6;
  localparam int line_gap = 3;      // Blank cycles after each line
  localparam int frame_gap = 5;     // Blank cycles around frame-valid
  localparam int frame_cycles = 3 * frame_gap + frame_rows * (frame_cols + line_gap);
  localparam int total_frames = 11;
  localparam int cycle_limit = 2 * total_frames * frame_cycles;
  localparam int drain_limit = 20;

  logic                           ccd_pixel_clk;
  logic                           reset;
  ccd_pipeline_pkg::raw_pixel_t   ccd_data;
  logic                           ccd_frame_valid;
  logic                           ccd_line_valid;
  logic                           start;
  logic                           hue_mode;
  logic [2:0]                     channel_enable;
  ccd_pipeline_pkg::pixel_word_t  pixel_word;
  logic                           pixel_word_valid;
  ccd_pipeline_pkg::frame_count_t frame_count;
  int                             test_id;
  logic                           test_end;
  int                             outstanding;
  int                             error_count;
  int                             word_count;
  int                             seed;
  int                             cycle_count = 0;

  ccd_pipeline_top #(
    .max_line_width (ccd_pipeline_pkg::default_max_line_width)
  ) UUT (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .reset            (reset),
    .ccd_data         (ccd_data),
    .ccd_frame_valid  (ccd_frame_valid),
    .ccd_line_valid   (ccd_line_valid),
    .start            (start),
    .hue_mode         (hue_mode),
    .channel_enable   (channel_enable),
    .pixel_word       (pixel_word),
    .pixel_word_valid (pixel_word_valid),
    .frame_count      (frame_count)
  );

  ccd_pipeline_checker #(
    .frame_cols (frame_cols),
    .frame_rows (frame_rows)
  ) u_checker (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .reset            (reset),
    .ccd_data         (ccd_data),
    .ccd_frame_valid  (ccd_frame_valid),
    .ccd_line_valid   (ccd_line_valid),
    .start            (start),
    .hue_mode         (hue_mode),
    .channel_enable   (channel_enable),
    .pixel_word       (pixel_word),
    .pixel_word_valid (pixel_word_valid),
    .frame_count      (frame_count),
    .test_id          (test_id),
    .test_end         (test_end),
    .outstanding      (outstanding),
    .error_count      (error_count),
    .word_count       (word_count)
  );

  always #20 ccd_pixel_clk = ~ccd_pixel_clk;   // 40 ns period

  // Run limit
  always @(posedge ccd_pixel_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ==============================
  // Stimulus helpers
  // ==============================
  // First four blocks directed in hue frames, grey red green blue
  function automatic ccd_pipeline_pkg::raw_pixel_t block_sample(
    input int r, input int c, input logic directed
  );
    int   k;
    logic top;
    logic left;
    ccd_pipeline_pkg::raw_pixel_t value;
    k = (r / 2) * (frame_cols / 2) + c / 2;
    top = (r % 2 == 0);
    left = (c % 2 == 0);
    if (directed && k < 4) begin
      case (k)
        0:       value = 12'h800;
        1:       value = (top && !left) ? 12'hfff : 12'h000;
        2:       value = (top == left) ? 12'hfff : 12'h000;    // Both greens
        default: value = (!top && left) ? 12'hfff : 12'h000;
      endcase
    end else begin
      value = ccd_pipeline_pkg::raw_pixel_t'($random(seed));
    end
    return value;
  endfunction

  task automatic begin_test(input int id, input logic mode, input logic [2:0] enables);
    test_id = id;
    hue_mode = mode;
    channel_enable = enables;
  endtask

  // Start is dropped at the opening of drop_row, -1 keeps it
  task automatic drive_frame(input logic directed, input logic start_value, input int drop_row);
    start = start_value;
    ccd_frame_valid = 1'b1;
    repeat (frame_gap) @(negedge ccd_pixel_clk);
    for (int r = 0; r < frame_rows; r++) begin
      if (r == drop_row) start = 1'b0;
      ccd_line_valid = 1'b1;
      for (int c = 0; c < frame_cols; c++) begin
        ccd_data = block_sample(r, c, directed);
        @(negedge ccd_pixel_clk);
      end
      ccd_line_valid = 1'b0;
      ccd_data = '0;
      repeat (line_gap) @(negedge ccd_pixel_clk);
    end
    repeat (frame_gap) @(negedge ccd_pixel_clk);
    ccd_frame_valid = 1'b0;
    repeat (frame_gap) @(negedge ccd_pixel_clk);
  endtask

  // Wait for due words, then let the checker report
  task automatic finish_test();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < drain_limit) begin
      @(negedge ccd_pixel_clk);
      waited++;
    end
    test_end = 1'b1;
    @(negedge ccd_pixel_clk);
    test_end = 1'b0;
    @(negedge ccd_pixel_clk);
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    seed = 32'h05f9_74ff;
    ccd_pixel_clk = 1'b0;
    reset = 1'b1;
    ccd_data = '0;
    ccd_frame_valid = 1'b0;
    ccd_line_valid = 1'b0;
    start = 1'b0;
    hue_mode = 1'b0;
    channel_enable = 3'b111;
    test_id = 0;
    test_end = 1'b0;
    repeat (5) @(negedge ccd_pixel_clk);
    reset = 1'b0;
    repeat (2) @(negedge ccd_pixel_clk);

    begin_test(1, 1'b0, 3'b111);
    drive_frame(1'b0, 1'b1, -1);
    drive_frame(1'b0, 1'b1, -1);
    finish_test();

    begin_test(2, 1'b0, 3'b010);     // Green field only
    drive_frame(1'b0, 1'b1, -1);
    finish_test();

    begin_test(3, 1'b1, 3'b111);
    drive_frame(1'b1, 1'b1, -1);
    drive_frame(1'b0, 1'b1, -1);
    finish_test();

    begin_test(4, 1'b0, 3'b111);
    drive_frame(1'b0, 1'b0, -1);     // Not captured
    drive_frame(1'b0, 1'b1, 2);      // Start drops mid-frame
    finish_test();

    begin_test(5, 1'b0, 3'b111);
    drive_frame(1'b0, 1'b1, -1);
    drive_frame(1'b0, 1'b1, -1);
    drive_frame(1'b0, 1'b0, -1);
    drive_frame(1'b0, 1'b1, -1);
    finish_test();

    $display("Totals: %0d words checked, %0d errors", word_count, error_count);
    if (error_count == 0 && word_count > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* ccd_pipeline.f */
common/ccd_pipeline_pkg.sv
ccd_capture/ccd_capture.sv
bayer_demosaic/bayer_demosaic.sv
verilog/rgb555_packer.sv
hue_calc/hue_calc.sv
verilog/pixel_word_select.sv
verilog/ccd_pipeline_top.sv
verification/ccd_pipeline_checker.sv
verification/ccd_pipeline_tb.sv

/* Makefile */
# Verilator build and run of the CCD pixel path testbench
SRCS := $(shell cat ccd_pipeline.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vccd_pipeline_tb: ccd_pipeline.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	  --top-module ccd_pipeline_tb -f ccd_pipeline.f -Mdir obj_dir

run: obj_dir/Vccd_pipeline_tb
	./obj_dir/Vccd_pipeline_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
